//--- cpu6502_pkg.sv
`default_nettype none

package cpu6502_pkg;

    // Bus widths
    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // Timing states, T0 is always the opcode fetch
    typedef enum logic [1:0] {
        T0 = 2'd0,
        T1 = 2'd1,
        T2 = 2'd2,
        T3 = 2'd3
    } tstate_t;

    // Immediate loads
    localparam logic [DATA_W-1:0] OP_LDA_IMM = 8'hA9;
    localparam logic [DATA_W-1:0] OP_LDX_IMM = 8'hA2;
    localparam logic [DATA_W-1:0] OP_LDY_IMM = 8'hA0;

    // Register transfers
    localparam logic [DATA_W-1:0] OP_TAX = 8'hAA;
    localparam logic [DATA_W-1:0] OP_TAY = 8'hA8;
    localparam logic [DATA_W-1:0] OP_TXA = 8'h8A;
    localparam logic [DATA_W-1:0] OP_TYA = 8'h98;
    localparam logic [DATA_W-1:0] OP_TXS = 8'h9A;
    localparam logic [DATA_W-1:0] OP_TSX = 8'hBA;

    // Absolute stores
    localparam logic [DATA_W-1:0] OP_STA_ABS = 8'h8D;
    localparam logic [DATA_W-1:0] OP_STX_ABS = 8'h8E;
    localparam logic [DATA_W-1:0] OP_STY_ABS = 8'h8C;

    // Control
    localparam logic [DATA_W-1:0] OP_JMP_ABS = 8'h4C;
    localparam logic [DATA_W-1:0] OP_NOP     = 8'hEA;

endpackage

`default_nettype wire

//--- timing_control.sv
`timescale 1ns/1ps
`default_nettype none

module timing_control (
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire [cpu6502_pkg::DATA_W-1:0]      i_data,
    input  cpu6502_pkg::tstate_t               i_tstate_next,
    output cpu6502_pkg::tstate_t               o_tstate,
    output logic [cpu6502_pkg::DATA_W-1:0]     o_ir,
    output logic                               o_sync
);

    cpu6502_pkg::tstate_t tstate;
    logic [cpu6502_pkg::DATA_W-1:0] ir;

    // T-state sequencing
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            tstate <= cpu6502_pkg::T0;
        end else begin
            tstate <= i_tstate_next;
        end
    end

    // Opcode is taken from the bus at the end of T0 and held until the next fetch
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ir <= cpu6502_pkg::OP_NOP;
        end else if (tstate == cpu6502_pkg::T0) begin
            ir <= i_data;
        end
    end

    assign o_tstate = tstate;
    assign o_ir     = ir;

    // The reset cycles sit in T0 but fetch nothing
    assign o_sync = (tstate == cpu6502_pkg::T0) && !i_reset;

endmodule

`default_nettype wire

//--- decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire [cpu6502_pkg::DATA_W-1:0] i_ir,
    input  cpu6502_pkg::tstate_t          i_tstate,
    output cpu6502_pkg::tstate_t          o_tstate_next,
    output logic                          o_dl_db,
    output logic                          o_dl_adl,
    output logic                          o_dl_adh,
    output logic                          o_pcl_adl,
    output logic                          o_pch_adh,
    output logic                          o_adl_pcl,
    output logic                          o_adh_pch,
    output logic                          o_i_pc,
    output logic                          o_x_sb,
    output logic                          o_y_sb,
    output logic                          o_ac_sb,
    output logic                          o_s_sb,
    output logic                          o_ac_db,
    output logic                          o_sb_db,
    output logic                          o_sb_x,
    output logic                          o_sb_y,
    output logic                          o_sb_ac,
    output logic                          o_sb_s,
    output logic                          o_dl_hold,
    output logic                          o_adl_abl,
    output logic                          o_adh_abh,
    output logic                          o_rw
);

    always_comb begin
        // Default: put PC on the address buses for the next read
        o_tstate_next = cpu6502_pkg::T0;
        o_dl_db   = 1'b0;
        o_dl_adl  = 1'b0;
        o_dl_adh  = 1'b0;
        o_pcl_adl = 1'b1;
        o_pch_adh = 1'b1;
        o_adl_pcl = 1'b0;
        o_adh_pch = 1'b0;
        o_i_pc    = 1'b0;
        o_x_sb    = 1'b0;
        o_y_sb    = 1'b0;
        o_ac_sb   = 1'b0;
        o_s_sb    = 1'b0;
        o_ac_db   = 1'b0;
        o_sb_db   = 1'b0;
        o_sb_x    = 1'b0;
        o_sb_y    = 1'b0;
        o_sb_ac   = 1'b0;
        o_sb_s    = 1'b0;
        o_dl_hold = 1'b0;
        o_adl_abl = 1'b1;
        o_adh_abh = 1'b1;
        o_rw      = 1'b1;

        case (i_tstate)
            cpu6502_pkg::T0: begin
                // Opcode fetch, every instruction reads PC+1 next
                o_i_pc        = 1'b1;
                o_tstate_next = cpu6502_pkg::T1;
            end
            cpu6502_pkg::T1: begin
                case (i_ir)
                    cpu6502_pkg::OP_LDA_IMM,
                    cpu6502_pkg::OP_LDX_IMM,
                    cpu6502_pkg::OP_LDY_IMM: begin
                        // Operand goes DL -> DB -> SB into the target
                        o_dl_db = 1'b1;
                        o_sb_db = 1'b1;
                        o_i_pc  = 1'b1;
                        o_sb_ac = (i_ir == cpu6502_pkg::OP_LDA_IMM);
                        o_sb_x  = (i_ir == cpu6502_pkg::OP_LDX_IMM);
                        o_sb_y  = (i_ir == cpu6502_pkg::OP_LDY_IMM);
                    end
                    cpu6502_pkg::OP_TAX: begin
                        o_ac_sb = 1'b1;
                        o_sb_x  = 1'b1;
                    end
                    cpu6502_pkg::OP_TAY: begin
                        o_ac_sb = 1'b1;
                        o_sb_y  = 1'b1;
                    end
                    cpu6502_pkg::OP_TXA: begin
                        o_x_sb  = 1'b1;
                        o_sb_ac = 1'b1;
                    end
                    cpu6502_pkg::OP_TYA: begin
                        o_y_sb  = 1'b1;
                        o_sb_ac = 1'b1;
                    end
                    cpu6502_pkg::OP_TXS: begin
                        o_x_sb = 1'b1;
                        o_sb_s = 1'b1;
                    end
                    cpu6502_pkg::OP_TSX: begin
                        o_s_sb = 1'b1;
                        o_sb_x = 1'b1;
                    end
                    cpu6502_pkg::OP_STA_ABS,
                    cpu6502_pkg::OP_STX_ABS,
                    cpu6502_pkg::OP_STY_ABS,
                    cpu6502_pkg::OP_JMP_ABS: begin
                        // Keep the low address byte, then read the high byte
                        o_dl_hold     = 1'b1;
                        o_i_pc        = 1'b1;
                        o_tstate_next = cpu6502_pkg::T2;
                    end
                    default: begin
                        // NOP and unknown opcodes: dummy read, no increment
                    end
                endcase
            end
            cpu6502_pkg::T2: begin
                // Effective address is {DL, hold}
                o_pcl_adl = 1'b0;
                o_pch_adh = 1'b0;
                o_dl_adl  = 1'b1;
                o_dl_adh  = 1'b1;
                if (i_ir == cpu6502_pkg::OP_JMP_ABS) begin
                    o_adl_pcl = 1'b1;
                    o_adh_pch = 1'b1;
                end else begin
                    // Store data reaches DB one cycle before the write
                    o_i_pc        = 1'b1;
                    o_rw          = 1'b0;
                    o_ac_db       = (i_ir == cpu6502_pkg::OP_STA_ABS);
                    o_x_sb        = (i_ir == cpu6502_pkg::OP_STX_ABS);
                    o_y_sb        = (i_ir == cpu6502_pkg::OP_STY_ABS);
                    o_sb_db       = (i_ir != cpu6502_pkg::OP_STA_ABS);
                    o_tstate_next = cpu6502_pkg::T3;
                end
            end
            default: begin
                // T3 is the write cycle, next fetch comes from PC
            end
        endcase
    end

endmodule

`default_nettype wire

//--- program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter #(
    parameter logic [cpu6502_pkg::ADDR_W-1:0] RESET_VECTOR = 16'h0000
) (
    input  wire                               i_clk,
    input  wire                               i_reset,
    input  wire                               i_i_pc,
    input  wire                               i_adl_pcl,
    input  wire                               i_adh_pch,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_adl,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_adh,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_pcl,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_pch
);

    logic [cpu6502_pkg::ADDR_W-1:0] pc;
    logic [cpu6502_pkg::ADDR_W-1:0] pc_inc;

    // Incrementer sits between the register and the address buses
    assign pc_inc = pc + {{(cpu6502_pkg::ADDR_W-1){1'b0}}, i_i_pc};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc <= RESET_VECTOR;
        end else begin
            pc[7:0]  <= i_adl_pcl ? i_adl : pc_inc[7:0];
            pc[15:8] <= i_adh_pch ? i_adh : pc_inc[15:8];
        end
    end

    assign o_pcl = pc_inc[7:0];
    assign o_pch = pc_inc[15:8];

endmodule

`default_nettype wire

//--- register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module register_bank #(
    parameter logic [cpu6502_pkg::ADDR_W-1:0] RESET_VECTOR = 16'h0000
) (
    input  wire                               i_clk,
    input  wire                               i_reset,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_data,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_bus_sb,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_bus_db,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_bus_adl,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_bus_adh,
    input  wire                               i_sb_x,
    input  wire                               i_sb_y,
    input  wire                               i_sb_ac,
    input  wire                               i_sb_s,
    input  wire                               i_dl_hold,
    input  wire                               i_adl_abl,
    input  wire                               i_adh_abh,
    input  wire                               i_rw,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_x,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_y,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_ac,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_s,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_dl,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_hold,
    output logic [cpu6502_pkg::ADDR_W-1:0]    o_address,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_data,
    output logic                              o_rw
);

    // Input latch is open during the read phase, so the byte is usable in its own cycle
    assign o_dl = i_data;

    // Programmer registers, all loaded from SB
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_x  <= '0;
            o_y  <= '0;
            o_ac <= '0;
            o_s  <= '0;
        end else begin
            if (i_sb_x)  o_x  <= i_bus_sb;
            if (i_sb_y)  o_y  <= i_bus_sb;
            if (i_sb_ac) o_ac <= i_bus_sb;
            if (i_sb_s)  o_s  <= i_bus_sb;
        end
    end

    // Low operand byte for absolute addressing
    always_ff @(posedge i_clk) begin
        if (i_dl_hold) begin
            o_hold <= o_dl;
        end
    end

    // Address, direction and write data for the next bus cycle
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_address <= RESET_VECTOR;
            o_rw      <= 1'b1;
            o_data    <= '0;
        end else begin
            if (i_adl_abl) o_address[7:0]  <= i_bus_adl;
            if (i_adh_abh) o_address[15:8] <= i_bus_adh;
            o_rw <= i_rw;
            if (!i_rw) begin
                o_data <= i_bus_db;
            end
        end
    end

endmodule

`default_nettype wire

//--- bus_routing.sv
`timescale 1ns/1ps
`default_nettype none

module bus_routing (
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_dl,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_hold,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_pcl,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_pch,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_x,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_y,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_ac,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_s,
    input  wire                               i_dl_db,
    input  wire                               i_dl_adl,
    input  wire                               i_dl_adh,
    input  wire                               i_pcl_adl,
    input  wire                               i_pch_adh,
    input  wire                               i_x_sb,
    input  wire                               i_y_sb,
    input  wire                               i_ac_sb,
    input  wire                               i_s_sb,
    input  wire                               i_ac_db,
    input  wire                               i_sb_db,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_bus_db,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_bus_sb,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_bus_adl,
    output logic [cpu6502_pkg::DATA_W-1:0]    o_bus_adh
);

    logic [cpu6502_pkg::DATA_W-1:0] db_src;
    logic [cpu6502_pkg::DATA_W-1:0] sb_src;

    // Disabled sources leave the precharged ones
    assign db_src = (i_dl_db ? i_dl : '1)
                  & (i_ac_db ? i_ac : '1);

    assign sb_src = (i_x_sb  ? i_x  : '1)
                  & (i_y_sb  ? i_y  : '1)
                  & (i_ac_sb ? i_ac : '1)
                  & (i_s_sb  ? i_s  : '1);

    // Pass switch shorts SB and DB, both sides then see every driver
    assign o_bus_db = i_sb_db ? (db_src & sb_src) : db_src;
    assign o_bus_sb = i_sb_db ? (db_src & sb_src) : sb_src;

    // Low address byte of absolute modes comes from the hold latch
    assign o_bus_adl = (i_pcl_adl ? i_pcl  : '1)
                     & (i_dl_adl  ? i_hold : '1);

    assign o_bus_adh = (i_pch_adh ? i_pch : '1)
                     & (i_dl_adh  ? i_dl  : '1);

endmodule

`default_nettype wire

//--- cpu6502.sv
`timescale 1ns/1ps
`default_nettype none

module cpu6502 #(
    parameter logic [cpu6502_pkg::ADDR_W-1:0] RESET_VECTOR = 16'h0000
) (
    input  wire                               i_clk,
    input  wire                               i_reset,
    output wire                               o_rw,
    output wire [cpu6502_pkg::ADDR_W-1:0]     o_address,
    input  wire [cpu6502_pkg::DATA_W-1:0]     i_data,
    output wire [cpu6502_pkg::DATA_W-1:0]     o_data,
    output wire                               o_sync
);

    // Internal buses
    wire [cpu6502_pkg::DATA_W-1:0] w_bus_db;
    wire [cpu6502_pkg::DATA_W-1:0] w_bus_sb;
    wire [cpu6502_pkg::DATA_W-1:0] w_bus_adl;
    wire [cpu6502_pkg::DATA_W-1:0] w_bus_adh;

    // Sequencing
    cpu6502_pkg::tstate_t w_tstate;
    cpu6502_pkg::tstate_t w_tstate_next;
    wire [cpu6502_pkg::DATA_W-1:0] w_ir;

    // Transfer controls
    wire w_dl_db, w_dl_adl, w_dl_adh;
    wire w_pcl_adl, w_pch_adh, w_adl_pcl, w_adh_pch, w_i_pc;
    wire w_x_sb, w_y_sb, w_ac_sb, w_s_sb, w_ac_db, w_sb_db;
    wire w_sb_x, w_sb_y, w_sb_ac, w_sb_s;
    wire w_dl_hold, w_adl_abl, w_adh_abh, w_rw;

    // Register values
    wire [cpu6502_pkg::DATA_W-1:0] w_pcl, w_pch;
    wire [cpu6502_pkg::DATA_W-1:0] w_x, w_y, w_ac, w_s;
    wire [cpu6502_pkg::DATA_W-1:0] w_dl, w_hold;

    timing_control i_timing_control (
        .i_clk(i_clk), .i_reset(i_reset), .i_data(i_data),
        .i_tstate_next(w_tstate_next), .o_tstate(w_tstate),
        .o_ir(w_ir), .o_sync(o_sync)
    );

    decoder i_decoder (
        .i_ir(w_ir), .i_tstate(w_tstate), .o_tstate_next(w_tstate_next),
        .o_dl_db(w_dl_db), .o_dl_adl(w_dl_adl), .o_dl_adh(w_dl_adh),
        .o_pcl_adl(w_pcl_adl), .o_pch_adh(w_pch_adh),
        .o_adl_pcl(w_adl_pcl), .o_adh_pch(w_adh_pch), .o_i_pc(w_i_pc),
        .o_x_sb(w_x_sb), .o_y_sb(w_y_sb), .o_ac_sb(w_ac_sb), .o_s_sb(w_s_sb),
        .o_ac_db(w_ac_db), .o_sb_db(w_sb_db),
        .o_sb_x(w_sb_x), .o_sb_y(w_sb_y), .o_sb_ac(w_sb_ac), .o_sb_s(w_sb_s),
        .o_dl_hold(w_dl_hold), .o_adl_abl(w_adl_abl), .o_adh_abh(w_adh_abh),
        .o_rw(w_rw)
    );

    program_counter #(.RESET_VECTOR(RESET_VECTOR)) i_program_counter (
        .i_clk(i_clk), .i_reset(i_reset), .i_i_pc(w_i_pc),
        .i_adl_pcl(w_adl_pcl), .i_adh_pch(w_adh_pch),
        .i_adl(w_bus_adl), .i_adh(w_bus_adh),
        .o_pcl(w_pcl), .o_pch(w_pch)
    );

    register_bank #(.RESET_VECTOR(RESET_VECTOR)) i_register_bank (
        .i_clk(i_clk), .i_reset(i_reset), .i_data(i_data),
        .i_bus_sb(w_bus_sb), .i_bus_db(w_bus_db),
        .i_bus_adl(w_bus_adl), .i_bus_adh(w_bus_adh),
        .i_sb_x(w_sb_x), .i_sb_y(w_sb_y), .i_sb_ac(w_sb_ac), .i_sb_s(w_sb_s),
        .i_dl_hold(w_dl_hold), .i_adl_abl(w_adl_abl), .i_adh_abh(w_adh_abh),
        .i_rw(w_rw),
        .o_x(w_x), .o_y(w_y), .o_ac(w_ac), .o_s(w_s),
        .o_dl(w_dl), .o_hold(w_hold),
        .o_address(o_address), .o_data(o_data), .o_rw(o_rw)
    );

    bus_routing i_bus_routing (
        .i_dl(w_dl), .i_hold(w_hold), .i_pcl(w_pcl), .i_pch(w_pch),
        .i_x(w_x), .i_y(w_y), .i_ac(w_ac), .i_s(w_s),
        .i_dl_db(w_dl_db), .i_dl_adl(w_dl_adl), .i_dl_adh(w_dl_adh),
        .i_pcl_adl(w_pcl_adl), .i_pch_adh(w_pch_adh),
        .i_x_sb(w_x_sb), .i_y_sb(w_y_sb), .i_ac_sb(w_ac_sb), .i_s_sb(w_s_sb),
        .i_ac_db(w_ac_db), .i_sb_db(w_sb_db),
        .o_bus_db(w_bus_db), .o_bus_sb(w_bus_sb),
        .o_bus_adl(w_bus_adl), .o_bus_adh(w_bus_adh)
    );

endmodule

`default_nettype wire

//--- tb_cpu6502_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu6502_assert (
    input wire i_clk,
    input wire i_reset,
    input wire i_rw,
    input wire i_sync
);

    // Bus stays in read through reset and on every opcode fetch
    a_read_in_reset_and_fetch: assert property (@(posedge i_clk)
        ($past(i_reset) || i_sync) |-> i_rw)
        else $error("write seen during reset or opcode fetch");

    // Shortest instruction is two cycles
    a_no_back_to_back_sync: assert property (@(posedge i_clk) disable iff (i_reset)
        i_sync |=> !i_sync)
        else $error("opcode fetch in two consecutive cycles");

    // Store write is always the last cycle of its instruction
    a_write_then_fetch: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_rw |=> i_sync)
        else $error("write cycle not followed by an opcode fetch");

endmodule

bind cpu6502 cpu6502_assert i_cpu6502_assert (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_rw(o_rw),
    .i_sync(o_sync)
);

`default_nettype wire

//--- tb_cpu6502.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu6502;

    localparam logic [15:0] START = 16'hC000;
    localparam int RESET_CYCLES = 8;
    localparam int SYNC_TIMEOUT = 200;

    logic        i_clk;
    logic        i_reset;
    logic [7:0]  i_data = 8'h00;
    wire         o_rw;
    wire  [15:0] o_address;
    wire  [7:0]  o_data;
    wire         o_sync;

    // 64 KiB memory with a loader port for use while the core is in reset
    logic [7:0]  mem [0:65535];
    logic        load_en;
    logic [15:0] load_addr;
    logic [7:0]  load_byte;
    logic [7:0]  prog [$];

    // Bus observations since the last reset
    int unsigned cyc;
    logic [15:0] sync_addr_q [$];
    int unsigned sync_cyc_q [$];
    logic [15:0] wr_addr_q [$];
    logic [7:0]  wr_data_q [$];

    cpu6502 #(.RESET_VECTOR(START)) i_cpu6502 (
        .i_clk(i_clk), .i_reset(i_reset), .o_rw(o_rw), .o_address(o_address),
        .i_data(i_data), .o_data(o_data), .o_sync(o_sync)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        if (load_en) begin
            mem[load_addr] <= load_byte;
        end else if (!o_rw && !i_reset) begin
            mem[o_address] <= o_data;
        end
    end

    // Read data settles on the falling edge before the core samples it
    always @(negedge i_clk) begin
        i_data <= mem[o_address];
    end

    always @(posedge i_clk) begin
        if (i_reset) begin
            cyc = 0;
            sync_addr_q.delete();
            sync_cyc_q.delete();
            wr_addr_q.delete();
            wr_data_q.delete();
        end else begin
            if (o_sync) begin
                sync_addr_q.push_back(o_address);
                sync_cyc_q.push_back(cyc);
            end
            if (!o_rw) begin
                wr_addr_q.push_back(o_address);
                wr_data_q.push_back(o_data);
            end
            cyc = cyc + 1;
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            stop_run("Stopping at first mismatch");
        end
    endtask

    task automatic begin_program();
        @(negedge i_clk);
        i_reset = 1'b1;
    endtask

    task automatic poke(input logic [15:0] addr, input logic [7:0] value);
        @(negedge i_clk);
        load_en   = 1'b1;
        load_addr = addr;
        load_byte = value;
    endtask

    task automatic load_program(input logic [15:0] base);
        int k;
        for (k = 0; k < prog.size(); k++) begin
            poke(base + 16'(k), prog[k]);
        end
    endtask

    // Bus must stay idle in read while reset is held
    task automatic run_program(input string name);
        int k;
        @(negedge i_clk);
        load_en = 1'b0;
        for (k = 0; k < RESET_CYCLES; k++) begin
            @(negedge i_clk);
            check({name, " reset rw"}, 32'd1, 32'(o_rw));
            check({name, " reset sync"}, 32'd0, 32'(o_sync));
            check({name, " reset data"}, 32'd0, 32'(o_data));
        end
        i_reset = 1'b0;
    endtask

    task automatic wait_syncs(input int count, input string name);
        int waited;
        waited = 0;
        while (sync_addr_q.size() < count) begin
            @(negedge i_clk);
            waited++;
            if (waited > SYNC_TIMEOUT) begin
                stop_run($sformatf("Timeout in %s waiting for %0d opcode fetches",
                                   name, count));
            end
        end
    endtask

    function automatic bit is_known(input logic [7:0] op);
        return op inside {cpu6502_pkg::OP_LDA_IMM, cpu6502_pkg::OP_LDX_IMM,
                          cpu6502_pkg::OP_LDY_IMM, cpu6502_pkg::OP_TAX,
                          cpu6502_pkg::OP_TAY, cpu6502_pkg::OP_TXA,
                          cpu6502_pkg::OP_TYA, cpu6502_pkg::OP_TXS,
                          cpu6502_pkg::OP_TSX, cpu6502_pkg::OP_STA_ABS,
                          cpu6502_pkg::OP_STX_ABS, cpu6502_pkg::OP_STY_ABS,
                          cpu6502_pkg::OP_JMP_ABS, cpu6502_pkg::OP_NOP};
    endfunction

    task automatic test_reset();
        begin_program();
        prog = '{cpu6502_pkg::OP_JMP_ABS, START[7:0], START[15:8]};
        load_program(START);
        run_program("reset");
        wait_syncs(2, "reset");
        check("reset first fetch", 32'(START), 32'(sync_addr_q[0]));
        check("reset loop fetch", 32'(START), 32'(sync_addr_q[1]));
    endtask

    task automatic test_store_a();
        logic [7:0]  value;
        logic [15:0] dest;
        logic [15:0] loop_at;
        value   = 8'($urandom);
        dest    = 16'h0200 + 16'($urandom % 32'h7000);
        loop_at = START + 16'd5;
        begin_program();
        prog = '{cpu6502_pkg::OP_LDA_IMM, value,
                 cpu6502_pkg::OP_STA_ABS, dest[7:0], dest[15:8],
                 cpu6502_pkg::OP_JMP_ABS, loop_at[7:0], loop_at[15:8]};
        load_program(START);
        poke(dest, ~value);
        run_program("store_a");
        wait_syncs(4, "store_a");
        check("store_a write count", 32'd1, 32'(wr_addr_q.size()));
        check("store_a write address", 32'(dest), 32'(wr_addr_q[0]));
        check("store_a write data", 32'(value), 32'(wr_data_q[0]));
        check("store_a memory", 32'(value), 32'(mem[dest]));
    endtask

    task automatic test_store_xy();
        logic [7:0]  vx;
        logic [7:0]  vy;
        logic [15:0] ax;
        logic [15:0] ay;
        logic [15:0] loop_at;
        vx      = 8'($urandom);
        vy      = 8'($urandom);
        ax      = 16'h0200 + 16'($urandom % 32'h3000);
        ay      = 16'h4000 + 16'($urandom % 32'h3000);
        loop_at = START + 16'd10;
        begin_program();
        prog = '{cpu6502_pkg::OP_LDX_IMM, vx, cpu6502_pkg::OP_LDY_IMM, vy,
                 cpu6502_pkg::OP_STX_ABS, ax[7:0], ax[15:8],
                 cpu6502_pkg::OP_STY_ABS, ay[7:0], ay[15:8],
                 cpu6502_pkg::OP_JMP_ABS, loop_at[7:0], loop_at[15:8]};
        load_program(START);
        poke(ax, ~vx);
        poke(ay, ~vy);
        run_program("store_xy");
        wait_syncs(6, "store_xy");
        check("store_xy write count", 32'd2, 32'(wr_addr_q.size()));
        check("store_xy x address", 32'(ax), 32'(wr_addr_q[0]));
        check("store_xy y address", 32'(ay), 32'(wr_addr_q[1]));
        check("store_xy x memory", 32'(vx), 32'(mem[ax]));
        check("store_xy y memory", 32'(vy), 32'(mem[ay]));
    endtask

    task automatic test_transfers();
        logic [7:0]  v1;
        logic [7:0]  v2;
        logic [15:0] a1;
        logic [15:0] a2;
        logic [15:0] loop_at;
        v1      = 8'($urandom);
        v2      = v1 ^ (8'd1 + 8'($urandom % 32'd255));
        a1      = 16'h0200 + 16'($urandom % 32'h3000);
        a2      = 16'h4000 + 16'($urandom % 32'h3000);
        loop_at = START + 16'h0011;
        begin_program();
        prog = '{cpu6502_pkg::OP_LDA_IMM, v1, cpu6502_pkg::OP_TAX, cpu6502_pkg::OP_TXS,
                 cpu6502_pkg::OP_TSX, cpu6502_pkg::OP_TXA, cpu6502_pkg::OP_TAY,
                 cpu6502_pkg::OP_TYA, cpu6502_pkg::OP_STA_ABS, a1[7:0], a1[15:8],
                 cpu6502_pkg::OP_LDX_IMM, v2, cpu6502_pkg::OP_TXA,
                 cpu6502_pkg::OP_STA_ABS, a2[7:0], a2[15:8],
                 cpu6502_pkg::OP_JMP_ABS, loop_at[7:0], loop_at[15:8]};
        load_program(START);
        poke(a1, ~v1);
        poke(a2, ~v2);
        run_program("transfers");
        wait_syncs(13, "transfers");
        check("transfers chain value", 32'(v1), 32'(mem[a1]));
        check("transfers txa value", 32'(v2), 32'(mem[a2]));
    endtask

    task automatic test_lengths();
        int          sizes [5];
        int          cycles [5];
        int          k;
        logic [15:0] exp_addr;
        logic [15:0] dest;
        logic [15:0] loop_at;
        sizes   = '{2, 1, 1, 3, 3};
        cycles  = '{2, 2, 2, 4, 3};
        dest    = 16'h0200 + 16'($urandom % 32'h7000);
        loop_at = START + 16'd7;
        begin_program();
        prog = '{cpu6502_pkg::OP_LDA_IMM, 8'($urandom), cpu6502_pkg::OP_TAX,
                 cpu6502_pkg::OP_NOP, cpu6502_pkg::OP_STA_ABS, dest[7:0], dest[15:8],
                 cpu6502_pkg::OP_JMP_ABS, loop_at[7:0], loop_at[15:8]};
        load_program(START);
        run_program("lengths");
        wait_syncs(6, "lengths");
        exp_addr = START;
        for (k = 0; k < 5; k++) begin
            check($sformatf("lengths fetch %0d address", k), 32'(exp_addr),
                  32'(sync_addr_q[k]));
            check($sformatf("lengths instruction %0d cycles", k), 32'(cycles[k]),
                  sync_cyc_q[k + 1] - sync_cyc_q[k]);
            exp_addr = exp_addr + 16'(sizes[k]);
        end
    endtask

    task automatic test_jump_unknown();
        logic [15:0] target;
        logic [15:0] loop_at;
        logic [7:0]  op;
        target  = 16'h1000 + 16'($urandom % 32'h8000);
        loop_at = target + 16'd1;
        do begin
            op = 8'($urandom);
        end while (is_known(op));
        begin_program();
        prog = '{cpu6502_pkg::OP_JMP_ABS, target[7:0], target[15:8]};
        load_program(START);
        prog = '{op, cpu6502_pkg::OP_JMP_ABS, loop_at[7:0], loop_at[15:8]};
        load_program(target);
        run_program("jump");
        wait_syncs(4, "jump");
        check("jump target fetch", 32'(target), 32'(sync_addr_q[1]));
        check("jump cycles", 32'd3, sync_cyc_q[1] - sync_cyc_q[0]);
        check("jump unknown opcode next fetch", 32'(loop_at), 32'(sync_addr_q[2]));
        check("jump unknown opcode cycles", 32'd2, sync_cyc_q[2] - sync_cyc_q[1]);
        check("jump write count", 32'd0, 32'(wr_addr_q.size()));
    endtask

    initial begin
        void'($urandom(32'h9e8f));
        i_reset   = 1'b1;
        load_en   = 1'b0;
        load_addr = 16'h0000;
        load_byte = 8'h00;
        test_reset();
        test_store_a();
        test_store_xy();
        test_transfers();
        test_lengths();
        test_jump_unknown();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
cpu6502_pkg.sv
timing_control.sv
decoder.sv
program_counter.sv
register_bank.sv
bus_routing.sv
cpu6502.sv
tb_cpu6502_assert.sv
tb_cpu6502.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu6502 testbench with Verilator
verilator --binary --timing --assert -f all.f --top-module tb_cpu6502 > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_cpu6502 > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
